// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// ********************
	// rv32 op major opcode
	// ********************

	// register-register alu instructions.
	localparam logic [6:0] OPCODE_OP = 7'b0110011;

	// funct7 of the m extension.
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// ********************
	// m extension funct3
	// ********************

	localparam logic [2:0] F3_MUL    = 3'b000;
	localparam logic [2:0] F3_MULH   = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU  = 3'b011;

	// bit 0 clear means signed, bit 1 set means remainder.
	localparam logic [2:0] F3_DIV    = 3'b100;
	localparam logic [2:0] F3_DIVU   = 3'b101;
	localparam logic [2:0] F3_REM    = 3'b110;
	localparam logic [2:0] F3_REMU   = 3'b111;

endpackage

// ==== src/pcpi_pkg.sv ====
package pcpi_pkg;

	// register width.
	localparam int XLEN = 32;

	// one extra bit holds the sign extension.
	localparam int OPW = XLEN + 1;

	// full product of two registers.
	localparam int PRODW = 2 * XLEN;

endpackage

// ==== src/pcpi_mdu_decode.sv ====
`timescale 1ns/1ps

module pcpi_mdu_decode
	import rv_isa_pkg::*;
#(
	parameter int EXTRA_INSN_FFS = 0
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid,
	input  logic [31:0] pcpi_insn,
	output logic        mul_any,
	output logic        mul_high,
	output logic        rs1_signed,
	output logic        rs2_signed,
	output logic        div_any,
	output logic        div_signed,
	output logic        div_rem
);
	logic       insn_match;
	logic       insn_valid;
	logic       insn_valid_q;
	logic       insn_hit;
	logic [2:0] funct3;

	assign funct3     = pcpi_insn[14:12];
	assign insn_match = (pcpi_insn[6:0] == OPCODE_OP) && (pcpi_insn[31:25] == FUNCT7_MULDIV);
	assign insn_valid = pcpi_valid && insn_match;

	always_ff @(posedge clk) begin
		if (!resetn)
			insn_valid_q <= 1'b0;
		else
			insn_valid_q <= insn_valid;
	end

	// live valid still qualifies the registered match.
	assign insn_hit = (EXTRA_INSN_FFS != 0) ? (pcpi_valid && insn_valid_q) : insn_valid;

	always_comb begin
		mul_any    = 1'b0;
		mul_high   = 1'b0;
		rs1_signed = 1'b0;
		rs2_signed = 1'b0;
		div_any    = 1'b0;
		div_signed = 1'b0;
		div_rem    = 1'b0;
		if (resetn && insn_hit) begin
			case (funct3)
				F3_MUL:    mul_any = 1'b1;
				F3_MULH:   {mul_any, mul_high, rs1_signed, rs2_signed} = 4'b1111;
				F3_MULHSU: {mul_any, mul_high, rs1_signed} = 3'b111;
				F3_MULHU:  {mul_any, mul_high} = 2'b11;
				F3_DIV:    {div_any, div_signed} = 2'b11;
				F3_DIVU:   div_any = 1'b1;
				F3_REM:    {div_any, div_signed, div_rem} = 3'b111;
				F3_REMU:   {div_any, div_rem} = 2'b11;
				default:   mul_any = 1'b0;
			endcase
		end
	end

endmodule

// ==== src/pcpi_fast_mul.sv ====
`timescale 1ns/1ps

module pcpi_fast_mul
	import pcpi_pkg::*;
#(
	parameter int EXTRA_MUL_FFS = 0,
	parameter int MUL_CLKGATE   = 0
) (
	input  logic            clk,
	input  logic            resetn,
	input  logic            mul_any,
	input  logic            mul_high,
	input  logic            rs1_signed,
	input  logic            rs2_signed,
	input  logic [XLEN-1:0] pcpi_rs1,
	input  logic [XLEN-1:0] pcpi_rs2,
	output logic            mul_ready,
	output logic [XLEN-1:0] mul_rd
);
	// stage whose active bit marks a finished product.
	localparam int LAST = (EXTRA_MUL_FFS != 0) ? 3 : 1;

	logic [3:0]              active;
	logic                    busy;
	logic                    start;
	logic                    high_q;
	logic [OPW-1:0]          op1;
	logic [OPW-1:0]          op2;
	logic [OPW-1:0]          op1_q;
	logic [OPW-1:0]          op2_q;
	logic [OPW-1:0]          mul_a;
	logic [OPW-1:0]          mul_b;
	logic signed [2*OPW-1:0] full_prod;
	logic [PRODW-1:0]        prod;
	logic [PRODW-1:0]        prod_q;
	logic [PRODW-1:0]        prod_out;
	logic                    ld_op_q;
	logic                    ld_prod;
	logic                    ld_prod_q;

	// ********************
	// stage sequencing
	// ********************

	// no restart while a result is still in the pipe.
	assign busy  = (EXTRA_MUL_FFS != 0) ? |active : |active[1:0];
	assign start = mul_any && !busy;

	always_ff @(posedge clk) begin
		if (!resetn)
			active <= '0;
		else
			active <= {active[2:0], start};
	end

	assign ld_op_q   = (MUL_CLKGATE == 0) || active[0];
	assign ld_prod   = (MUL_CLKGATE == 0) || ((EXTRA_MUL_FFS != 0) ? active[1] : active[0]);
	assign ld_prod_q = (MUL_CLKGATE == 0) || active[2];

	// ********************
	// datapath
	// ********************

	// operands extended by signedness.
	always_ff @(posedge clk) begin
		if (start) begin
			op1    <= rs1_signed ? {pcpi_rs1[XLEN-1], pcpi_rs1} : {1'b0, pcpi_rs1};
			op2    <= rs2_signed ? {pcpi_rs2[XLEN-1], pcpi_rs2} : {1'b0, pcpi_rs2};
			high_q <= mul_high;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_op_q) begin
			op1_q <= op1;
			op2_q <= op2;
		end
	end

	assign mul_a = (EXTRA_MUL_FFS != 0) ? op1_q : op1;
	assign mul_b = (EXTRA_MUL_FFS != 0) ? op2_q : op2;

	assign full_prod = $signed(mul_a) * $signed(mul_b);

	always_ff @(posedge clk) begin
		if (ld_prod)
			prod <= full_prod[PRODW-1:0];
	end

	always_ff @(posedge clk) begin
		if (ld_prod_q)
			prod_q <= prod;
	end

	assign prod_out = (EXTRA_MUL_FFS != 0) ? prod_q : prod;

	// upper word for the mulh family.
	assign mul_rd    = high_q ? prod_out[PRODW-1:XLEN] : prod_out[XLEN-1:0];
	assign mul_ready = active[LAST];

endmodule

// ==== src/pcpi_div.sv ====
`timescale 1ns/1ps

module pcpi_div
	import pcpi_pkg::*;
(
	input  logic            clk,
	input  logic            resetn,
	input  logic            div_any,
	input  logic            div_signed,
	input  logic            div_rem,
	input  logic [XLEN-1:0] pcpi_rs1,
	input  logic [XLEN-1:0] pcpi_rs2,
	output logic            div_wait,
	output logic            div_ready,
	output logic [XLEN-1:0] div_rd
);
	localparam int CNTW = $clog2(XLEN + 1);

	logic            running;
	logic            done_hold;
	logic            start;
	logic            finish;
	logic [CNTW-1:0] count;
	logic [XLEN-1:0] quo;
	logic [XLEN-1:0] rem;
	logic [XLEN-1:0] divisor;
	logic            quo_neg;
	logic            rem_neg;
	logic            rem_op;
	logic [XLEN-1:0] abs_rs1;
	logic [XLEN-1:0] abs_rs2;
	logic [OPW-1:0]  rem_shift;
	logic [OPW-1:0]  diff;
	logic            fits;

	// done_hold keeps a held request from restarting right after ready.
	assign start  = div_any && !running && !done_hold;
	assign finish = running && (count == '0);

	assign abs_rs1 = (div_signed && pcpi_rs1[XLEN-1]) ? -pcpi_rs1 : pcpi_rs1;
	assign abs_rs2 = (div_signed && pcpi_rs2[XLEN-1]) ? -pcpi_rs2 : pcpi_rs2;

	// ********************
	// control
	// ********************

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running   <= 1'b0;
			done_hold <= 1'b0;
			div_wait  <= 1'b0;
			div_ready <= 1'b0;
		end else begin
			div_ready <= 1'b0;
			done_hold <= 1'b0;
			if (start) begin
				running  <= 1'b1;
				div_wait <= 1'b1;
			end else if (finish) begin
				running   <= 1'b0;
				div_wait  <= 1'b0;
				div_ready <= 1'b1;
				done_hold <= 1'b1;
			end
		end
	end

	// ********************
	// restoring divider
	// ********************

	// partial remainder with the next dividend bit shifted in.
	assign rem_shift = {rem, quo[XLEN-1]};
	assign diff      = rem_shift - {1'b0, divisor};
	assign fits      = !diff[OPW-1];

	always_ff @(posedge clk) begin
		if (start) begin
			quo     <= abs_rs1;
			rem     <= '0;
			divisor <= abs_rs2;
			count   <= CNTW'(XLEN);
			// zero divisor keeps the all-ones quotient.
			quo_neg <= div_signed && (pcpi_rs1[XLEN-1] ^ pcpi_rs2[XLEN-1]) && (|pcpi_rs2);
			rem_neg <= div_signed && pcpi_rs1[XLEN-1];
			rem_op  <= div_rem;
		end else if (running && !finish) begin
			rem   <= fits ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
			quo   <= {quo[XLEN-2:0], fits};
			count <= count - 1'b1;
		end
	end

	// sign fixup on the last cycle.
	always_ff @(posedge clk) begin
		if (finish) begin
			if (rem_op)
				div_rd <= rem_neg ? -rem : rem;
			else
				div_rd <= quo_neg ? -quo : quo;
		end
	end

endmodule

// ==== src/pcpi_mdu.sv ====
`timescale 1ns/1ps

module pcpi_mdu
	import pcpi_pkg::*;
#(
	parameter int EXTRA_INSN_FFS = 0,
	parameter int EXTRA_MUL_FFS  = 0,
	parameter int MUL_CLKGATE    = 0
) (
	input  logic            clk,
	input  logic            resetn,
	input  logic            pcpi_valid,
	input  logic [31:0]     pcpi_insn,
	input  logic [XLEN-1:0] pcpi_rs1,
	input  logic [XLEN-1:0] pcpi_rs2,
	output logic            pcpi_wr,
	output logic [XLEN-1:0] pcpi_rd,
	output logic            pcpi_wait,
	output logic            pcpi_ready
);
	logic            mul_any;
	logic            mul_high;
	logic            rs1_signed;
	logic            rs2_signed;
	logic            div_any;
	logic            div_signed;
	logic            div_rem;
	logic            mul_ready;
	logic [XLEN-1:0] mul_rd;
	logic            div_wait;
	logic            div_ready;
	logic [XLEN-1:0] div_rd;

	pcpi_mdu_decode #(
		.EXTRA_INSN_FFS(EXTRA_INSN_FFS)
	) u_decode (
		.clk       (clk),
		.resetn    (resetn),
		.pcpi_valid(pcpi_valid),
		.pcpi_insn (pcpi_insn),
		.mul_any   (mul_any),
		.mul_high  (mul_high),
		.rs1_signed(rs1_signed),
		.rs2_signed(rs2_signed),
		.div_any   (div_any),
		.div_signed(div_signed),
		.div_rem   (div_rem)
	);

	pcpi_fast_mul #(
		.EXTRA_MUL_FFS(EXTRA_MUL_FFS),
		.MUL_CLKGATE  (MUL_CLKGATE)
	) u_mul (
		.clk       (clk),
		.resetn    (resetn),
		.mul_any   (mul_any),
		.mul_high  (mul_high),
		.rs1_signed(rs1_signed),
		.rs2_signed(rs2_signed),
		.pcpi_rs1  (pcpi_rs1),
		.pcpi_rs2  (pcpi_rs2),
		.mul_ready (mul_ready),
		.mul_rd    (mul_rd)
	);

	pcpi_div u_div (
		.clk       (clk),
		.resetn    (resetn),
		.div_any   (div_any),
		.div_signed(div_signed),
		.div_rem   (div_rem),
		.pcpi_rs1  (pcpi_rs1),
		.pcpi_rs2  (pcpi_rs2),
		.div_wait  (div_wait),
		.div_ready (div_ready),
		.div_rd    (div_rd)
	);

	// one instruction in flight, so at most one unit is ready.
	assign pcpi_ready = mul_ready || div_ready;
	assign pcpi_wr    = pcpi_ready;
	assign pcpi_rd    = div_ready ? div_rd : mul_rd;
	assign pcpi_wait  = div_wait;

endmodule

// ==== verification/mdu_model.svh ====
`ifndef MDU_MODEL_SVH
`define MDU_MODEL_SVH

// ********************
// reference model
// ********************

// expected rd from 64-bit arithmetic.
function automatic logic [XLEN-1:0] expected_rd(input logic [2:0] funct3,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	logic signed [PRODW-1:0] sa;
	logic signed [PRODW-1:0] sb;
	logic [PRODW-1:0]        ua;
	logic [PRODW-1:0]        ub;
	logic [PRODW-1:0]        res;
	sa = $signed(a);
	sb = $signed(b);
	ua = a;
	ub = b;
	case (funct3)
		F3_MUL, F3_MULHU: res = ua * ub;
		F3_MULH:          res = sa * sb;
		F3_MULHSU:        res = sa * $signed(ub);
		F3_DIV, F3_REM: begin
			// most-negative over minus one wraps back to the dividend in 32 bits.
			if (b == '0)
				res = (funct3 == F3_REM) ? ua : '1;
			else
				res = (funct3 == F3_REM) ? sa % sb : sa / sb;
		end
		default: begin
			if (b == '0)
				res = (funct3 == F3_REMU) ? ua : '1;
			else
				res = (funct3 == F3_REMU) ? ua % ub : ua / ub;
		end
	endcase
	if (funct3 inside {F3_MULH, F3_MULHSU, F3_MULHU})
		return res[PRODW-1:XLEN];
	return res[XLEN-1:0];
endfunction

// ********************
// compare
// ********************

task automatic check_equal(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
		input string what);
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	end
endtask

`endif

// ==== verification/tb_pcpi_mdu.sv ====
`timescale 1ns/1ps

module tb_pcpi_mdu
	import rv_isa_pkg::*, pcpi_pkg::*;
#(
	parameter int EXTRA_INSN_FFS = 0,
	parameter int EXTRA_MUL_FFS  = 0,
	parameter int MUL_CLKGATE    = 0
);
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 3;
	localparam int N_RANDOM     = 400;
	localparam int N_CORNER     = 128;
	localparam int N_BAD        = 12;
	localparam int N_TRANS      = N_RANDOM + N_CORNER + N_BAD + 1;
	localparam int MUL_LAT      = ((EXTRA_MUL_FFS != 0) ? 4 : 2) + EXTRA_INSN_FFS;
	localparam int DIV_MAX      = 36 + EXTRA_INSN_FFS;

	logic            clk;
	logic            resetn;
	logic            pcpi_valid;
	logic [31:0]     pcpi_insn;
	logic [XLEN-1:0] pcpi_rs1;
	logic [XLEN-1:0] pcpi_rs2;
	logic            pcpi_wr;
	logic [XLEN-1:0] pcpi_rd;
	logic            pcpi_wait;
	logic            pcpi_ready;
	integer          seed;
	logic [XLEN-1:0] corner_vals [4];

	`include "mdu_model.svh"

	pcpi_mdu #(
		.EXTRA_INSN_FFS(EXTRA_INSN_FFS),
		.EXTRA_MUL_FFS (EXTRA_MUL_FFS),
		.MUL_CLKGATE   (MUL_CLKGATE)
	) u_dut (
		.clk       (clk),
		.resetn    (resetn),
		.pcpi_valid(pcpi_valid),
		.pcpi_insn (pcpi_insn),
		.pcpi_rs1  (pcpi_rs1),
		.pcpi_rs2  (pcpi_rs2),
		.pcpi_wr   (pcpi_wr),
		.pcpi_rd   (pcpi_rd),
		.pcpi_wait (pcpi_wait),
		.pcpi_ready(pcpi_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(N_TRANS * 40 * CLK_PERIOD + (RESET_CYCLES + 1) * CLK_PERIOD);
		$display("Timeout: the transactions did not complete in the expected time");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	// outputs are settled 1 ns after the edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			next_cycle();
			check_equal(pcpi_ready, 1'b0, "ready while idle");
			check_equal(pcpi_wr, 1'b0, "wr while idle");
			check_equal(pcpi_wait, 1'b0, "wait while idle");
		end
	endtask

	// ********************
	// transactions
	// ********************

	task automatic pick_operand(output logic [XLEN-1:0] v);
		logic [31:0] r;
		r = $random(seed);
		if (r[6:4] == 3'b000)
			v = corner_vals[r[1:0]];
		else
			v = $random(seed);
	endtask

	task automatic run_op(input logic [2:0] funct3, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic [XLEN-1:0] exp;
		logic [31:0]     regs;
		logic            is_div;
		int              n;
		int              pulses;
		exp        = expected_rd(funct3, a, b);
		is_div     = funct3[2];
		regs       = $random(seed);
		pcpi_insn  = {FUNCT7_MULDIV, regs[14:5], funct3, regs[4:0], OPCODE_OP};
		pcpi_rs1   = a;
		pcpi_rs2   = b;
		pcpi_valid = 1'b1;
		// n is the edge at which the core samples what is seen now.
		n = 0;
		while (!pcpi_ready) begin
			next_cycle();
			n++;
			if (n > DIV_MAX + 4)
				abort_run($sformatf("No ready for funct3 %0d after %0d cycles", funct3, n));
			if (!pcpi_ready) begin
				check_equal(pcpi_wait, is_div && (n > EXTRA_INSN_FFS), "wait level");
				check_equal(pcpi_wr, 1'b0, "wr before ready");
			end
		end
		check_equal(pcpi_wr, 1'b1, "wr with ready");
		check_equal(pcpi_wait, 1'b0, "wait with ready");
		check_equal(pcpi_rd, exp, $sformatf("rd of funct3 %0d for %h, %h", funct3, a, b));
		if (is_div)
			check_equal(n <= DIV_MAX, 1'b1, "divide latency");
		else
			check_equal(n, MUL_LAT, "multiply latency");
		// valid stays high for the cycle in which the core takes the result.
		pulses = 1;
		next_cycle();
		if (pcpi_ready)
			pulses++;
		check_equal(pulses, 1, "ready pulses while valid held");
		check_equal(pcpi_wr, 1'b0, "wr after ready");
		check_equal(pcpi_wait, 1'b0, "wait after ready");
		pcpi_valid = 1'b0;
		idle_cycles(1 + ($unsigned($random(seed)) % 2));
	endtask

	task automatic run_bad(input logic [31:0] insn);
		pcpi_rs1   = $random(seed);
		pcpi_rs2   = $random(seed);
		pcpi_insn  = insn;
		pcpi_valid = 1'b1;
		idle_cycles(40);
		pcpi_valid = 1'b0;
		idle_cycles(1);
	endtask

	initial begin : stimulus
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [31:0]     r;
		seed        = 32'hfce;
		corner_vals = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
		resetn      = 1'b0;
		pcpi_valid  = 1'b0;
		pcpi_insn   = '0;
		pcpi_rs1    = '0;
		pcpi_rs2    = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		resetn = 1'b1;
		idle_cycles(10);
		for (int i = 0; i < N_RANDOM; i++) begin
			pick_operand(a);
			pick_operand(b);
			r = $random(seed);
			run_op(r[2:0], a, b);
		end
		// every corner pair on every operation.
		for (int i = 0; i < N_CORNER; i++)
			run_op(i[2:0], corner_vals[i[4:3]], corner_vals[i[6:5]]);
		// op-imm opcode, bad funct7, plain alu op.
		for (int i = 0; i < N_BAD / 3; i++) begin
			r = $random(seed);
			run_bad({FUNCT7_MULDIV, r[17:0], 7'b0010011});
			run_bad({7'b0000101, r[17:0], OPCODE_OP});
			run_bad({7'b0000000, r[17:0], OPCODE_OP});
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+verification
src/rv_isa_pkg.sv
src/pcpi_pkg.sv
src/pcpi_mdu_decode.sv
src/pcpi_fast_mul.sv
src/pcpi_div.sv
src/pcpi_mdu.sv
verification/tb_pcpi_mdu.sv

// ==== Makefile ====
TOP            ?= tb_pcpi_mdu
SIM_F          ?= sim.f
LOG            ?= sim.log
EXTRA_INSN_FFS ?= 0
EXTRA_MUL_FFS  ?= 0
MUL_CLKGATE    ?= 0
VERILATOR      ?= verilator
OBJ_DIR        ?= obj_dir

PARAMS = -GEXTRA_INSN_FFS=$(EXTRA_INSN_FFS) -GEXTRA_MUL_FFS=$(EXTRA_MUL_FFS) \
	-GMUL_CLKGATE=$(MUL_CLKGATE)

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-f $(SIM_F) $(PARAMS)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
